// ==== rtl/pma_pkg.sv ====
package pma_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] addr_t;
  typedef logic [1:0]  region_idx_t;
  typedef logic [3:0]  region_mask_t;
  typedef logic [15:0] count_t;

  localparam int unsigned PMA_NUM_REGIONS = 4;

  // Inclusive address ranges where index 0 has the highest priority
  localparam addr_t PMA_REGION_BASE [PMA_NUM_REGIONS] = '{
    32'h0000_0000,
    32'h0000_8000,
    32'h1000_0000,
    32'h2000_0000
  };

  localparam addr_t PMA_REGION_LAST [PMA_NUM_REGIONS] = '{
    32'h0000_FFFF,
    32'h0001_7FFF,
    32'h1000_0FFF,
    32'h2FFF_FFFF
  };

  // Attribute masks with bit n for region n
  // Region 1 overlaps the upper half of region 0
  localparam region_mask_t PMA_REGION_MAIN       = 4'b1001;
  localparam region_mask_t PMA_REGION_BUFFERABLE = 4'b1010;
  localparam region_mask_t PMA_REGION_CACHEABLE  = 4'b1001;

  // MPU transaction states
  typedef enum logic [1:0] {
    MPU_IDLE  = 2'd0,
    MPU_BUS   = 2'd1,
    MPU_FAULT = 2'd2,
    MPU_RESP  = 2'd3
  } mpu_state_e;

endpackage : pma_pkg

// ==== rtl/pma_status_if.sv ====
`timescale 1ns/1ps

interface pma_status_if import pma_pkg::*; ();

  logic         have_match;
  region_idx_t  match_idx;
  region_mask_t match_list;
  logic         main;
  logic         bufferable;
  logic         cacheable;

  // Lookup result of the region matcher
  modport matcher (
    output have_match, match_idx, match_list, main, bufferable, cacheable
  );

  modport mpu (
    input have_match, main, bufferable, cacheable
  );

  modport monitor (
    input have_match, match_idx, match_list, main, bufferable, cacheable
  );

endinterface : pma_status_if

// ==== rtl/pma_event_if.sv ====
`timescale 1ns/1ps

interface pma_event_if ();

  // Flags are only valid while accept is high
  logic accept;
  logic fault;
  logic misaligned;
  logic instr;

  modport source (
    output accept, fault, misaligned, instr
  );

  modport sink (
    input accept, fault, misaligned, instr
  );

endinterface : pma_event_if

// ==== rtl/pma_region_match.sv ====
`timescale 1ns/1ps

module pma_region_match import pma_pkg::*; (
  input  addr_t                addr_i,
  pma_status_if.matcher        status
);

  region_mask_t match_list;
  region_idx_t  match_idx;
  logic         have_match;

  // Compare the address against every region range
  always_comb begin
    match_list = '0;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      match_list[i] = (addr_i >= PMA_REGION_BASE[i]) &&
                      (addr_i <= PMA_REGION_LAST[i]);
    end
  end

  // Lowest set index wins, so scan downwards and let the last hit stick
  always_comb begin
    match_idx = '0;
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_list[i]) begin
        match_idx = region_idx_t'(i);
      end
    end
  end

  assign have_match = |match_list;

  assign status.match_list = match_list;
  assign status.match_idx  = match_idx;
  assign status.have_match = have_match;

  // Unmapped addresses fall back to I/O without any attributes
  always_comb begin
    if (have_match) begin
      status.main       = PMA_REGION_MAIN[status.match_idx];
      status.bufferable = PMA_REGION_BUFFERABLE[status.match_idx];
      status.cacheable  = PMA_REGION_CACHEABLE[status.match_idx];
    end else begin
      status.main       = 1'b0;
      status.bufferable = 1'b0;
      status.cacheable  = 1'b0;
    end
  end

endmodule : pma_region_match

// ==== rtl/pma_mpu.sv ====
`timescale 1ns/1ps

module pma_mpu import pma_pkg::*; (
  input  logic          clk_ungated,
  input  logic          rst_n,

  // Request channel
  input  logic          req_valid_i,
  output logic          req_ready_o,
  input  addr_t         req_addr_i,
  input  logic          req_we_i,
  input  logic          req_instr_i,

  // Bus channel
  output logic          bus_valid_o,
  input  logic          bus_ready_i,
  output addr_t         bus_addr_o,
  output logic          bus_we_o,
  output logic          bus_bufferable_o,
  output logic          bus_cacheable_o,

  // Response channel
  output logic          rsp_valid_o,
  input  logic          rsp_ready_i,
  output logic          rsp_fault_o,

  pma_status_if.mpu     status,
  pma_event_if.source   events
);

  mpu_state_e state_q;
  mpu_state_e state_d;

  logic  accept;
  logic  misaligned;
  logic  is_io;
  logic  allow;
  logic  fault_q;
  addr_t addr_q;
  logic  we_q;
  logic  bufferable_q;
  logic  cacheable_q;

  assign req_ready_o = (state_q == MPU_IDLE);
  assign accept      = req_valid_i && req_ready_o;

  // Allow rule on the live request
  assign misaligned = |req_addr_i[1:0];
  assign is_io      = !status.have_match || !status.main;
  assign allow      = !(is_io && (req_instr_i || misaligned));

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (accept) begin
          state_d = allow ? MPU_BUS : MPU_FAULT;
        end
      end
      MPU_BUS: begin
        if (bus_ready_i) begin
          state_d = MPU_RESP;
        end
      end
      MPU_FAULT: state_d = MPU_RESP;
      MPU_RESP: begin
        if (rsp_ready_i) begin
          state_d = MPU_IDLE;
        end
      end
      default: state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
      fault_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        fault_q <= !allow;
      end
    end
  end

  // Payload held for the whole transaction
  always_ff @(posedge clk_ungated) begin
    if (accept) begin
      addr_q       <= req_addr_i;
      we_q         <= req_we_i;
      bufferable_q <= status.bufferable;
      cacheable_q  <= status.cacheable;
    end
  end

  assign bus_valid_o      = (state_q == MPU_BUS);
  assign bus_addr_o       = addr_q;
  assign bus_we_o         = we_q;
  assign bus_bufferable_o = bufferable_q;
  assign bus_cacheable_o  = cacheable_q;

  assign rsp_valid_o = (state_q == MPU_RESP);
  assign rsp_fault_o = fault_q;

  // Event strobes for the counters
  assign events.accept     = accept;
  assign events.fault      = !allow;
  assign events.misaligned = misaligned;
  assign events.instr      = req_instr_i;

endmodule : pma_mpu

// ==== rtl/pma_event_counters.sv ====
`timescale 1ns/1ps

module pma_event_counters import pma_pkg::*; (
  input  logic          clk_ungated,
  input  logic          rst_n,

  pma_status_if.monitor status,
  pma_event_if.sink     events,

  output count_t        cnt_access_o,
  output count_t        cnt_fault_o,
  output count_t        cnt_multi_o,
  output count_t        cnt_misaligned_o
);

  count_t cnt_access_q;
  count_t cnt_fault_q;
  count_t cnt_multi_q;
  count_t cnt_misaligned_q;
  logic   multi_match;

  // Increment that sticks at the maximum
  function automatic count_t sat_inc(input count_t value, input logic hit);
    count_t result;
    result = value;
    if (hit && (value != '1)) begin
      result = value + count_t'(1);
    end
    return result;
  endfunction

  // Overlapping regions both report a match
  assign multi_match = ($countones(status.match_list) > 1);

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      cnt_access_q     <= '0;
      cnt_fault_q      <= '0;
      cnt_multi_q      <= '0;
      cnt_misaligned_q <= '0;
    end else if (events.accept) begin
      cnt_access_q     <= sat_inc(cnt_access_q, 1'b1);
      cnt_fault_q      <= sat_inc(cnt_fault_q, events.fault);
      cnt_multi_q      <= sat_inc(cnt_multi_q, multi_match);
      cnt_misaligned_q <= sat_inc(cnt_misaligned_q, events.misaligned);
    end
  end

  assign cnt_access_o     = cnt_access_q;
  assign cnt_fault_o      = cnt_fault_q;
  assign cnt_multi_o      = cnt_multi_q;
  assign cnt_misaligned_o = cnt_misaligned_q;

endmodule : pma_event_counters

// ==== rtl/pma_subsys_top.sv ====
`timescale 1ns/1ps

module pma_subsys_top import pma_pkg::*; (
  input  logic   clk_ungated,
  input  logic   rst_n,

  // Request channel
  input  logic   req_valid_i,
  output logic   req_ready_o,
  input  addr_t  req_addr_i,
  input  logic   req_we_i,
  input  logic   req_instr_i,

  // Bus channel
  output logic   bus_valid_o,
  input  logic   bus_ready_i,
  output addr_t  bus_addr_o,
  output logic   bus_we_o,
  output logic   bus_bufferable_o,
  output logic   bus_cacheable_o,

  // Response channel
  output logic   rsp_valid_o,
  input  logic   rsp_ready_i,
  output logic   rsp_fault_o,

  // Event counts
  output count_t cnt_access_o,
  output count_t cnt_fault_o,
  output count_t cnt_multi_o,
  output count_t cnt_misaligned_o
);

  pma_status_if status_if ();
  pma_event_if  event_if ();

  // Lookup runs on the live request address
  pma_region_match u_region_match (
    .addr_i (req_addr_i),
    .status (status_if.matcher)
  );

  pma_mpu u_mpu (
    .clk_ungated      (clk_ungated),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_addr_i       (req_addr_i),
    .req_we_i         (req_we_i),
    .req_instr_i      (req_instr_i),
    .bus_valid_o      (bus_valid_o),
    .bus_ready_i      (bus_ready_i),
    .bus_addr_o       (bus_addr_o),
    .bus_we_o         (bus_we_o),
    .bus_bufferable_o (bus_bufferable_o),
    .bus_cacheable_o  (bus_cacheable_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i),
    .rsp_fault_o      (rsp_fault_o),
    .status           (status_if.mpu),
    .events           (event_if.source)
  );

  pma_event_counters u_event_counters (
    .clk_ungated      (clk_ungated),
    .rst_n            (rst_n),
    .status           (status_if.monitor),
    .events           (event_if.sink),
    .cnt_access_o     (cnt_access_o),
    .cnt_fault_o      (cnt_fault_o),
    .cnt_multi_o      (cnt_multi_o),
    .cnt_misaligned_o (cnt_misaligned_o)
  );

endmodule : pma_subsys_top

// ==== tests/tb_pma_ref.svh ====
`ifndef TB_PMA_REF_SVH
`define TB_PMA_REF_SVH

// Expected outcome of one access from the region table rules
function automatic void pma_expect(
  input  addr_t addr,
  input  logic  instr,
  output logic  fault,
  output logic  bufferable,
  output logic  cacheable,
  output logic  multi
);
  logic [3:0] hit;
  logic       is_main;
  hit[0] = (addr <= 32'h0000_FFFF);
  hit[1] = (addr >= 32'h0000_8000) && (addr <= 32'h0001_7FFF);
  hit[2] = (addr >= 32'h1000_0000) && (addr <= 32'h1000_0FFF);
  hit[3] = (addr >= 32'h2000_0000) && (addr <= 32'h2FFF_FFFF);
  multi  = ($countones(hit) > 1);
  // Lower index wins and no match means plain I/O
  if (hit[0]) begin
    {is_main, bufferable, cacheable} = 3'b101;
  end else if (hit[1]) begin
    {is_main, bufferable, cacheable} = 3'b010;
  end else if (hit[2]) begin
    {is_main, bufferable, cacheable} = 3'b000;
  end else if (hit[3]) begin
    {is_main, bufferable, cacheable} = 3'b111;
  end else begin
    {is_main, bufferable, cacheable} = 3'b000;
  end
  // I/O refuses fetches and misaligned accesses
  fault = !is_main && (instr || (addr[1:0] != 2'b00));
endfunction

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[FAIL] %0t ns %s expected %0b actual %0b", $time, name, exp, act);
    value_errors++;
  end
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
  if (act !== exp) begin
    $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
    value_errors++;
  end
endtask

task automatic check_count(input string name, input count_t exp, input count_t act);
  if (act !== exp) begin
    $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
    value_errors++;
  end
endtask

`endif

// ==== tests/tb_pma_subsys.sv ====
`timescale 1ns/1ps

module tb_pma_subsys import pma_pkg::*; ();

  localparam logic [31:0] SEED           = 32'h5b85_6c4c;
  localparam int          NUM_TXNS       = 200;
  localparam int          TIMEOUT_CYCLES = 200;

  // One expected transaction
  typedef struct packed {
    addr_t addr;
    logic  we;
    logic  fault;
    logic  bufferable;
    logic  cacheable;
  } txn_t;

  logic   clk_ungated;
  logic   rst_n;
  logic   req_valid_i;
  logic   req_ready_o;
  addr_t  req_addr_i;
  logic   req_we_i;
  logic   req_instr_i;
  logic   bus_valid_o;
  logic   bus_ready_i;
  addr_t  bus_addr_o;
  logic   bus_we_o;
  logic   bus_bufferable_o;
  logic   bus_cacheable_o;
  logic   rsp_valid_o;
  logic   rsp_ready_i;
  logic   rsp_fault_o;
  count_t cnt_access_o;
  count_t cnt_fault_o;
  count_t cnt_multi_o;
  count_t cnt_misaligned_o;

  int          value_errors;
  int          other_errors;
  integer      stim_seed;
  integer      ready_seed;
  logic [31:0] ready_roll;
  logic        timed_out;
  txn_t        exp_q[$];
  txn_t        cur;
  txn_t        held;
  logic        bus_seen;
  logic        bus_hold;
  logic        rsp_hold;
  count_t      exp_access;
  count_t      exp_fault;
  count_t      exp_multi;
  count_t      exp_misaligned;

  `include "tb_pma_ref.svh"

  pma_subsys_top dut (.*);

  initial begin
    clk_ungated = 1'b0;
    forever #50 clk_ungated = ~clk_ungated;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    other_errors++;
  endtask

  // Steer a random value into a region, the overlap or unmapped space
  function automatic addr_t steer_addr(input int unsigned kind, input logic [31:0] r);
    case (kind)
      0: return 32'h0000_0000 + (r & 32'h0000_7FFF);
      1: return 32'h0000_8000 + (r & 32'h0000_7FFF);
      2: return 32'h0001_0000 + (r & 32'h0000_7FFF);
      3: return 32'h1000_0000 + (r & 32'h0000_0FFF);
      4: return 32'h2000_0000 + (r & 32'h0FFF_FFFF);
      default: return 32'h4000_0000 + (r & 32'h3FFF_FFFF);
    endcase
  endfunction

  task automatic send_request();
    logic [31:0] r;
    logic [31:0] flags;
    int unsigned kind;
    logic        multi;
    txn_t        t;
    kind  = $unsigned($random(stim_seed)) % 6;
    r     = $random(stim_seed);
    flags = $random(stim_seed);
    t.addr = steer_addr(kind, r);
    if (flags[2]) begin
      t.addr[1:0] = 2'b00;
    end
    t.we = flags[1];
    pma_expect(t.addr, flags[0], t.fault, t.bufferable, t.cacheable, multi);
    exp_access     = exp_access + 1;
    exp_fault      = exp_fault + t.fault;
    exp_multi      = exp_multi + multi;
    exp_misaligned = exp_misaligned + (t.addr[1:0] != 2'b00);
    exp_q.push_back(t);
    req_valid_i = 1'b1;
    req_addr_i  = t.addr;
    req_we_i    = t.we;
    req_instr_i = flags[0];
    // Ready was high at this falling edge, so the next rising edge accepts
    @(negedge clk_ungated);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_ready(output logic ok);
    int cycles;
    cycles = 0;
    while (!req_ready_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_ungated);
      cycles++;
    end
    ok = req_ready_o;
  endtask

  task automatic wait_drain(output logic ok);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_ungated);
      cycles++;
    end
    ok = (exp_q.size() == 0);
  endtask

  // Bus responder and response sink with random ready delays
  always @(negedge clk_ungated) begin
    if (rst_n) begin
      ready_roll  = $random(ready_seed);
      bus_ready_i = bus_valid_o && (ready_roll[1:0] == 2'b00);
      rsp_ready_i = rsp_valid_o && (ready_roll[3:2] != 2'b11);
    end
  end

  // Compare the bus and response channels against the expected queue
  always @(posedge clk_ungated) begin
    if (rst_n) begin
      if (bus_hold) begin
        check_bit("bus_valid_o", 1'b1, bus_valid_o);
        check_addr("bus_addr_o", held.addr, bus_addr_o);
        check_bit("bus_we_o", held.we, bus_we_o);
        check_bit("bus_bufferable_o", held.bufferable, bus_bufferable_o);
        check_bit("bus_cacheable_o", held.cacheable, bus_cacheable_o);
        check_bit("req_ready_o", 1'b0, req_ready_o);
      end
      if (rsp_hold) begin
        check_bit("rsp_valid_o", 1'b1, rsp_valid_o);
        check_bit("rsp_fault_o", held.fault, rsp_fault_o);
        check_bit("req_ready_o", 1'b0, req_ready_o);
      end
      if (bus_valid_o && bus_ready_i) begin
        if (exp_q.size() == 0) begin
          report_error("bus transfer without an outstanding request");
        end else begin
          cur = exp_q[0];
          if (cur.fault || bus_seen) begin
            report_error("unexpected bus transfer for this access");
          end
          check_addr("bus_addr_o", cur.addr, bus_addr_o);
          check_bit("bus_we_o", cur.we, bus_we_o);
          check_bit("bus_bufferable_o", cur.bufferable, bus_bufferable_o);
          check_bit("bus_cacheable_o", cur.cacheable, bus_cacheable_o);
          bus_seen = 1'b1;
        end
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          report_error("response without an outstanding request");
        end else begin
          cur = exp_q.pop_front();
          check_bit("rsp_fault_o", cur.fault, rsp_fault_o);
          if (!cur.fault && !bus_seen) begin
            report_error("allowed access answered without a bus transfer");
          end
          bus_seen = 1'b0;
        end
      end
      // Remember outputs under back-pressure for the next edge
      bus_hold        = bus_valid_o && !bus_ready_i;
      rsp_hold        = rsp_valid_o && !rsp_ready_i;
      held.addr       = bus_addr_o;
      held.we         = bus_we_o;
      held.bufferable = bus_bufferable_o;
      held.cacheable  = bus_cacheable_o;
      held.fault      = rsp_fault_o;
    end
  end

  initial begin
    logic ok;
    value_errors   = 0;
    other_errors   = 0;
    stim_seed      = SEED;
    ready_seed     = ~SEED;
    timed_out      = 1'b0;
    bus_seen       = 1'b0;
    bus_hold       = 1'b0;
    rsp_hold       = 1'b0;
    exp_access     = '0;
    exp_fault      = '0;
    exp_multi      = '0;
    exp_misaligned = '0;
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_we_i       = 1'b0;
    req_instr_i    = 1'b0;
    bus_ready_i    = 1'b0;
    rsp_ready_i    = 1'b0;
    repeat (8) @(negedge clk_ungated);
    rst_n = 1'b1;
    @(negedge clk_ungated);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    check_bit("bus_valid_o", 1'b0, bus_valid_o);
    check_bit("rsp_valid_o", 1'b0, rsp_valid_o);
    check_count("cnt_access_o", '0, cnt_access_o);
    check_count("cnt_fault_o", '0, cnt_fault_o);
    check_count("cnt_multi_o", '0, cnt_multi_o);
    check_count("cnt_misaligned_o", '0, cnt_misaligned_o);
    for (int n = 0; n < NUM_TXNS && !timed_out; n++) begin
      wait_ready(ok);
      if (ok) begin
        send_request();
      end else begin
        report_error("request channel did not become ready in time");
        timed_out = 1'b1;
      end
    end
    wait_drain(ok);
    if (!ok) begin
      report_error("outstanding transactions did not complete in time");
    end
    check_count("cnt_access_o", exp_access, cnt_access_o);
    check_count("cnt_fault_o", exp_fault, cnt_fault_o);
    check_count("cnt_multi_o", exp_multi, cnt_multi_o);
    check_count("cnt_misaligned_o", exp_misaligned, cnt_misaligned_o);
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_pma_subsys

// ==== sim.f ====
+incdir+tests
rtl/pma_pkg.sv
rtl/pma_status_if.sv
rtl/pma_event_if.sv
rtl/pma_region_match.sv
rtl/pma_mpu.sv
rtl/pma_event_counters.sv
rtl/pma_subsys_top.sv
tests/tb_pma_subsys.sv

// ==== Bender.yml ====
package:
  name: pma_subsys

sources:
  - rtl/pma_pkg.sv
  - rtl/pma_status_if.sv
  - rtl/pma_event_if.sv
  - rtl/pma_region_match.sv
  - rtl/pma_mpu.sv
  - rtl/pma_event_counters.sv
  - rtl/pma_subsys_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_pma_subsys.sv
